// ==== logic/video_pkg.sv ====
`default_nettype none

package video_pkg;

   // Raster reduced for simulation
   localparam int ML = 4;
   localparam int HP = 16;
   localparam int MR = 4;
   localparam int WA = ML + HP + MR;
   localparam int VP = 8;

   // Averaging windows
   localparam int KH = 4;
   localparam int KV = 4;
   localparam int NBLK = HP / KH;

   // One band of clocks plus two
   localparam int BAND_DELAY = WA * KV + 2;

   localparam int PIX_W = 24;
   localparam int GRAY_W = 8;

   // Luma weights add up to 256
   localparam logic [GRAY_W-1:0] WR = 8'd77;
   localparam logic [GRAY_W-1:0] WG = 8'd150;
   localparam logic [GRAY_W-1:0] WB = 8'd29;

   localparam int BLK_SUM_W = $clog2(KH * KV * 255 + 1);
   localparam int LIN_SUM_W = $clog2(HP * KV * 255 + 1);
   localparam int FRM_SUM_W = $clog2(HP * VP * 255 + 1);

   localparam int COL_W = $clog2(HP + 1);
   localparam int BLK_IDX_W = $clog2(NBLK);
   localparam int BAND_CNT_W = $clog2(KV);
   localparam int DLY_PTR_W = $clog2(BAND_DELAY);

endpackage

`default_nettype wire

// ==== logic/mode_pkg.sv ====
`default_nettype none

package mode_pkg;

   // Bits [2:1] pick the window kind, bit 0 the polarity
   typedef enum logic [2:0] {
      DIRECT    = 3'd0,
      INV       = 3'd1,
      BLK_DARK  = 3'd2,
      BLK_LIGHT = 3'd3,
      LIN_DARK  = 3'd4,
      LIN_LIGHT = 3'd5,
      FRM_DARK  = 3'd6,
      FRM_LIGHT = 3'd7
   } oper_mode_t;

   // Indexed by oper_mode_t
   localparam logic [3:0] LED_CODE [8] = '{
      4'b0000, 4'b0001, 4'b1000, 4'b1001,
      4'b0100, 4'b0101, 4'b0010, 4'b0011
   };

endpackage

`default_nettype wire

// ==== logic/video_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface video_if;
   import video_pkg::*;

   logic             hs;
   logic             vs;
   logic             de;
   logic [PIX_W-1:0] data;

   modport src (output hs, vs, de, data);
   modport snk (input hs, vs, de, data);

endinterface

`default_nettype wire

// ==== logic/rgb_to_gray.sv ====
`timescale 1ns/10ps
`default_nettype none

module rgb_to_gray (
   input  wire  [video_pkg::PIX_W-1:0]  pix_i,
   output logic [video_pkg::GRAY_W-1:0] gray_o
);
   import video_pkg::*;

   logic [GRAY_W-1:0]   r;
   logic [GRAY_W-1:0]   g;
   logic [GRAY_W-1:0]   b;
   logic [2*GRAY_W-1:0] wsum;

   assign r = pix_i[3*GRAY_W-1:2*GRAY_W];
   assign g = pix_i[2*GRAY_W-1:GRAY_W];
   assign b = pix_i[GRAY_W-1:0];

   // Upper byte is the gray level
   assign wsum = WR * r + WG * g + WB * b;
   assign gray_o = wsum[2*GRAY_W-1:GRAY_W];

endmodule

`default_nettype wire

// ==== logic/blk_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module blk_buffer (
   input  wire                          vin_clk_i,
   input  wire                          rst_n,
   input  wire                          acc_de_i,
   input  wire  [video_pkg::GRAY_W-1:0] acc_gray_i,
   input  wire                          band_done_i,
   input  wire                          cmp_de_i,
   input  wire  [video_pkg::GRAY_W-1:0] cmp_gray_i,
   output logic                         rx_o
);
   import video_pkg::*;

   logic [COL_W-1:0]     acc_col;
   logic [COL_W-1:0]     cmp_col;
   logic [BLK_IDX_W-1:0] acc_blk;
   logic [BLK_IDX_W-1:0] cmp_blk;
   logic [BLK_SUM_W-1:0] blk_sum [NBLK];
   logic [BLK_SUM_W-1:0] blk_ref [NBLK];
   logic [BLK_SUM_W-1:0] cmp_scaled;

   // Live and delayed pixel index within the active line
   always_ff @(posedge vin_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         acc_col <= '0;
         cmp_col <= '0;
      end else begin
         acc_col <= acc_de_i ? acc_col + 1'b1 : '0;
         cmp_col <= cmp_de_i ? cmp_col + 1'b1 : '0;
      end
   end

   assign acc_blk = BLK_IDX_W'(acc_col / KH);
   assign cmp_blk = BLK_IDX_W'(cmp_col / KH);

   always_ff @(posedge vin_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NBLK; i++) begin
            blk_sum[i] <= '0;
            blk_ref[i] <= '0;
         end
      end else if (band_done_i) begin
         for (int i = 0; i < NBLK; i++) begin
            blk_ref[i] <= blk_sum[i];
            blk_sum[i] <= '0;
         end
      end else if (acc_de_i) begin
         blk_sum[acc_blk] <= blk_sum[acc_blk] + acc_gray_i;
      end
   end

   // Gray scaled to the block pixel count
   assign cmp_scaled = cmp_gray_i * BLK_SUM_W'(KH * KV);
   assign rx_o = cmp_scaled < blk_ref[cmp_blk];

   a_acc_col: assert property (@(posedge vin_clk_i) disable iff (!rst_n)
      acc_de_i |-> acc_col < HP) else $error("live line longer than HP");
   a_cmp_col: assert property (@(posedge vin_clk_i) disable iff (!rst_n)
      cmp_de_i |-> cmp_col < HP) else $error("delayed line longer than HP");

endmodule

`default_nettype wire

// ==== logic/lin_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module lin_buffer (
   input  wire                          vin_clk_i,
   input  wire                          rst_n,
   input  wire                          acc_de_i,
   input  wire  [video_pkg::GRAY_W-1:0] acc_gray_i,
   input  wire                          band_done_i,
   input  wire  [video_pkg::GRAY_W-1:0] cmp_gray_i,
   output logic                         rx_o
);
   import video_pkg::*;

   logic [LIN_SUM_W-1:0] lin_sum;
   logic [LIN_SUM_W-1:0] lin_ref;
   logic [LIN_SUM_W-1:0] cmp_scaled;

   always_ff @(posedge vin_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         lin_sum <= '0;
         lin_ref <= '0;
      end else if (band_done_i) begin
         lin_ref <= lin_sum;
         lin_sum <= '0;
      end else if (acc_de_i) begin
         lin_sum <= lin_sum + acc_gray_i;
      end
   end

   // Whole band is HP by KV pixels
   assign cmp_scaled = cmp_gray_i * LIN_SUM_W'(HP * KV);
   assign rx_o = cmp_scaled < lin_ref;

endmodule

`default_nettype wire

// ==== logic/frm_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module frm_buffer (
   input  wire                          vin_clk_i,
   input  wire                          rst_n,
   input  wire                          acc_vs_i,
   input  wire                          acc_de_i,
   input  wire  [video_pkg::GRAY_W-1:0] acc_gray_i,
   input  wire  [video_pkg::GRAY_W-1:0] cmp_gray_i,
   output logic                         rx_o
);
   import video_pkg::*;

   logic                 acc_vs_r;
   logic                 frm_armed;
   logic [FRM_SUM_W-1:0] frm_sum;
   logic [FRM_SUM_W-1:0] frm_pend;
   logic [FRM_SUM_W-1:0] frm_ref;
   logic [FRM_SUM_W-1:0] cmp_scaled;

   always_ff @(posedge vin_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         acc_vs_r <= 1'b0;
         frm_armed <= 1'b0;
         frm_sum <= '0;
         frm_pend <= '0;
         frm_ref <= '0;
      end else begin
         acc_vs_r <= acc_vs_i;
         if (acc_vs_i && !acc_vs_r) begin
            frm_pend <= frm_sum;
            frm_sum <= '0;
            frm_armed <= 1'b1;
         end else if (acc_de_i) begin
            frm_sum <= frm_sum + acc_gray_i;
         end
         // Delayed frame has drained by the first live pixel of the next one
         if (acc_de_i && frm_armed) begin
            frm_ref <= frm_pend;
            frm_armed <= 1'b0;
         end
      end
   end

   assign cmp_scaled = cmp_gray_i * FRM_SUM_W'(HP * VP);
   assign rx_o = cmp_scaled < frm_ref;

endmodule

`default_nettype wire

// ==== logic/delay_line.sv ====
`timescale 1ns/10ps
`default_nettype none

module delay_line (
   input wire    vin_clk_i,
   input wire    rst_n,
   video_if.snk  d,
   video_if.src  q
);
   import video_pkg::*;

   logic [2:0]           sync_mem [BAND_DELAY];
   logic [PIX_W-1:0]     data_mem [BAND_DELAY];
   logic [DLY_PTR_W-1:0] ptr;

   // Slot under ptr was written one full lap ago
   always_ff @(posedge vin_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
         for (int i = 0; i < BAND_DELAY; i++) begin
            sync_mem[i] <= 3'b000;
         end
      end else begin
         ptr <= (ptr == DLY_PTR_W'(BAND_DELAY - 1)) ? '0 : ptr + 1'b1;
         sync_mem[ptr] <= {d.hs, d.vs, d.de};
      end
   end

   always_ff @(posedge vin_clk_i) begin
      data_mem[ptr] <= d.data;
   end

   assign q.hs = sync_mem[ptr][2];
   assign q.vs = sync_mem[ptr][1];
   assign q.de = sync_mem[ptr][0];
   assign q.data = data_mem[ptr];

endmodule

`default_nettype wire

// ==== logic/mode_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module mode_ctrl (
   input  wire                  vin_clk_i,
   input  wire                  rst_n,
   input  wire                  mode_next_i,
   input  wire                  mode_flip_i,
   input  wire                  led_en_i,
   output mode_pkg::oper_mode_t mode_o,
   output logic [3:0]           led_o
);
   import mode_pkg::*;

   oper_mode_t mode_q;

   always_ff @(posedge vin_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         mode_q <= BLK_DARK;
      end else if (mode_next_i) begin
         // Next window kind wraps from the frame kinds to DIRECT/INV
         mode_q <= oper_mode_t'({mode_q[2:1] + 2'd1, mode_q[0]});
      end else if (mode_flip_i) begin
         mode_q <= oper_mode_t'({mode_q[2:1], ~mode_q[0]});
      end
   end

   assign mode_o = mode_q;
   assign led_o = led_en_i ? LED_CODE[mode_q] : 4'b0000;

   a_mode_known: assert property (@(posedge vin_clk_i) disable iff (!rst_n)
      !$isunknown(mode_o)) else $error("mode_o unknown after reset");

endmodule

`default_nettype wire

// ==== logic/binarize_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module binarize_top (
   input  wire                         vin_clk_i,
   input  wire                         rst_n,
   input  wire                         vin_de_i,
   input  wire                         vin_hs_i,
   input  wire                         vin_vs_i,
   input  wire  [video_pkg::PIX_W-1:0] vin_data_i,
   input  wire                         mode_next_i,
   input  wire                         mode_flip_i,
   input  wire                         led_en_i,
   output logic                        vout_de_o,
   output logic                        vout_hs_o,
   output logic                        vout_vs_o,
   output logic [video_pkg::PIX_W-1:0] vout_data_o,
   output logic [3:0]                  led_o
);
   import video_pkg::*;
   import mode_pkg::*;

   video_if live ();
   video_if dly ();

   logic [GRAY_W-1:0]     gray_live;
   logic [GRAY_W-1:0]     gray_dly;
   logic                  live_de_r;
   logic [BAND_CNT_W-1:0] band_cnt;
   logic                  band_done;
   logic                  blk_rx;
   logic                  lin_rx;
   logic                  frm_rx;
   oper_mode_t            mode;
   logic                  px_inv;

   always_ff @(posedge vin_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         live.hs <= 1'b0;
         live.vs <= 1'b0;
         live.de <= 1'b0;
      end else begin
         live.hs <= vin_hs_i;
         live.vs <= vin_vs_i;
         live.de <= vin_de_i;
      end
   end

   always_ff @(posedge vin_clk_i) begin
      live.data <= vin_data_i;
   end

   // Band counter on live line ends
   always_ff @(posedge vin_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         live_de_r <= 1'b0;
         band_cnt <= '0;
         band_done <= 1'b0;
      end else begin
         live_de_r <= live.de;
         band_done <= 1'b0;
         if (live.vs) begin
            band_cnt <= '0;
         end else if (live_de_r && !live.de) begin
            band_cnt <= (band_cnt == BAND_CNT_W'(KV - 1)) ? '0 : band_cnt + 1'b1;
            // Registered so the load follows the last delayed pixel of the old band
            band_done <= (band_cnt == BAND_CNT_W'(KV - 1));
         end
      end
   end

   rgb_to_gray i_gray_live (.pix_i(live.data), .gray_o(gray_live));
   rgb_to_gray i_gray_dly  (.pix_i(dly.data),  .gray_o(gray_dly));

   blk_buffer i_blk_buffer (
      .vin_clk_i   (vin_clk_i),
      .rst_n       (rst_n),
      .acc_de_i    (live.de),
      .acc_gray_i  (gray_live),
      .band_done_i (band_done),
      .cmp_de_i    (dly.de),
      .cmp_gray_i  (gray_dly),
      .rx_o        (blk_rx)
   );

   lin_buffer i_lin_buffer (
      .vin_clk_i   (vin_clk_i),
      .rst_n       (rst_n),
      .acc_de_i    (live.de),
      .acc_gray_i  (gray_live),
      .band_done_i (band_done),
      .cmp_gray_i  (gray_dly),
      .rx_o        (lin_rx)
   );

   frm_buffer i_frm_buffer (
      .vin_clk_i  (vin_clk_i),
      .rst_n      (rst_n),
      .acc_vs_i   (live.vs),
      .acc_de_i   (live.de),
      .acc_gray_i (gray_live),
      .cmp_gray_i (gray_dly),
      .rx_o       (frm_rx)
   );

   delay_line i_delay_line (.vin_clk_i(vin_clk_i), .rst_n(rst_n), .d(live), .q(dly));

   mode_ctrl i_mode_ctrl (
      .vin_clk_i   (vin_clk_i),
      .rst_n       (rst_n),
      .mode_next_i (mode_next_i),
      .mode_flip_i (mode_flip_i),
      .led_en_i    (led_en_i),
      .mode_o      (mode),
      .led_o       (led_o)
   );

   always_comb begin
      case (mode)
         DIRECT:    px_inv = 1'b0;
         INV:       px_inv = 1'b1;
         BLK_DARK:  px_inv = blk_rx;
         BLK_LIGHT: px_inv = ~blk_rx;
         LIN_DARK:  px_inv = lin_rx;
         LIN_LIGHT: px_inv = ~lin_rx;
         FRM_DARK:  px_inv = frm_rx;
         FRM_LIGHT: px_inv = ~frm_rx;
      endcase
   end

   always_ff @(posedge vin_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         vout_hs_o <= 1'b0;
         vout_vs_o <= 1'b0;
         vout_de_o <= 1'b0;
      end else begin
         vout_hs_o <= dly.hs;
         vout_vs_o <= dly.vs;
         vout_de_o <= dly.de;
      end
   end

   always_ff @(posedge vin_clk_i) begin
      vout_data_o <= dly.data ^ {PIX_W{px_inv}};
   end

   a_no_de_in_vs: assert property (@(posedge vin_clk_i) disable iff (!rst_n)
      !(live.vs && live.de)) else $error("active pixel during vertical sync");

endmodule

`default_nettype wire

// ==== testbench/tb_binarize.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_binarize;
   import video_pkg::*;
   import mode_pkg::*;

   localparam int FRAME_LINES = VP + 6;
   localparam int LAT = BAND_DELAY + 2;
   localparam int PIX_TIMEOUT = 2000;

   logic             vin_clk_i;
   logic             rst_n;
   logic             vin_de_i;
   logic             vin_hs_i;
   logic             vin_vs_i;
   logic [PIX_W-1:0] vin_data_i;
   logic             mode_next_i;
   logic             mode_flip_i;
   logic             led_en_i;
   logic             vout_de_o;
   logic             vout_hs_o;
   logic             vout_vs_o;
   logic [PIX_W-1:0] vout_data_o;
   logic [3:0]       led_o;

   logic [PIX_W-1:0] frame_pix [VP][HP];
   logic [PIX_W-1:0] out_q [$];
   logic [2:0]       in_hist [256];
   int               since_rst;
   int               errors;
   int               checks;
   int               prev_sum;
   oper_mode_t       exp_mode;

   binarize_top dut0 (
      .vin_clk_i   (vin_clk_i),
      .rst_n       (rst_n),
      .vin_de_i    (vin_de_i),
      .vin_hs_i    (vin_hs_i),
      .vin_vs_i    (vin_vs_i),
      .vin_data_i  (vin_data_i),
      .mode_next_i (mode_next_i),
      .mode_flip_i (mode_flip_i),
      .led_en_i    (led_en_i),
      .vout_de_o   (vout_de_o),
      .vout_hs_o   (vout_hs_o),
      .vout_vs_o   (vout_vs_o),
      .vout_data_o (vout_data_o),
      .led_o       (led_o)
   );

   always #2 vin_clk_i = ~vin_clk_i;

   // Strobes must reappear LAT cycles later; active pixels are queued
   always @(negedge vin_clk_i) begin
      in_hist[since_rst % 256] = {vin_hs_i, vin_vs_i, vin_de_i};
      if (rst_n && since_rst >= LAT) begin
         checks++;
         assert ({vout_hs_o, vout_vs_o, vout_de_o} == in_hist[(since_rst - LAT) % 256]) else begin
            errors++;
            $display("mismatch at %0t: {vout_hs_o,vout_vs_o,vout_de_o} expected %b got %b",
                     $time, in_hist[(since_rst - LAT) % 256], {vout_hs_o, vout_vs_o, vout_de_o});
         end
      end
      if (rst_n && vout_de_o) begin
         out_q.push_back(vout_data_o);
      end
      since_rst = rst_n ? since_rst + 1 : 0;
   end

   function automatic int gray_of(logic [PIX_W-1:0] p);
      int r;
      int g;
      int b;
      r = p[23:16];
      g = p[15:8];
      b = p[7:0];
      return (77 * r + 150 * g + 29 * b) >> 8;
   endfunction

   function automatic logic [3:0] led_pattern(oper_mode_t m);
      case (m)
         DIRECT:    return 4'b0000;
         INV:       return 4'b0001;
         BLK_DARK:  return 4'b1000;
         BLK_LIGHT: return 4'b1001;
         LIN_DARK:  return 4'b0100;
         LIN_LIGHT: return 4'b0101;
         FRM_DARK:  return 4'b0010;
         default:   return 4'b0011;
      endcase
   endfunction

   function automatic oper_mode_t step_window(oper_mode_t m);
      case (m)
         DIRECT:    return BLK_DARK;
         BLK_DARK:  return LIN_DARK;
         LIN_DARK:  return FRM_DARK;
         FRM_DARK:  return DIRECT;
         INV:       return BLK_LIGHT;
         BLK_LIGHT: return LIN_LIGHT;
         LIN_LIGHT: return FRM_LIGHT;
         default:   return INV;
      endcase
   endfunction

   function automatic oper_mode_t swap_polarity(oper_mode_t m);
      case (m)
         DIRECT:    return INV;
         INV:       return DIRECT;
         BLK_DARK:  return BLK_LIGHT;
         BLK_LIGHT: return BLK_DARK;
         LIN_DARK:  return LIN_LIGHT;
         LIN_LIGHT: return LIN_DARK;
         FRM_DARK:  return FRM_LIGHT;
         default:   return FRM_DARK;
      endcase
   endfunction

   // Window means from the frame held in frame_pix
   function automatic logic inv_expected(oper_mode_t m, int ln, int col);
      int   g;
      int   blk;
      int   lin;
      int   b0;
      int   c0;
      logic dark;
      g = gray_of(frame_pix[ln][col]);
      blk = 0;
      lin = 0;
      b0 = (ln / KV) * KV;
      c0 = (col / KH) * KH;
      for (int y = b0; y < b0 + KV; y++) begin
         for (int x = 0; x < HP; x++) begin
            lin += gray_of(frame_pix[y][x]);
            if (x >= c0 && x < c0 + KH) begin
               blk += gray_of(frame_pix[y][x]);
            end
         end
      end
      case (m)
         DIRECT:              dark = 1'b0;
         INV:                 dark = 1'b1;
         BLK_DARK, BLK_LIGHT: dark = g * KH * KV < blk;
         LIN_DARK, LIN_LIGHT: dark = g * HP * KV < lin;
         default:             dark = g * HP * VP < prev_sum;
      endcase
      return (m == BLK_LIGHT || m == LIN_LIGHT || m == FRM_LIGHT) ? !dark : dark;
   endfunction

   task automatic apply_reset();
      rst_n = 1'b0;
      vin_de_i = 1'b0;
      vin_hs_i = 1'b0;
      vin_vs_i = 1'b0;
      vin_data_i = '0;
      mode_next_i = 1'b0;
      mode_flip_i = 1'b0;
      led_en_i = 1'b0;
      repeat (16) @(posedge vin_clk_i);
      #0.5;
      rst_n = 1'b1;
      exp_mode = BLK_DARK;
      prev_sum = 0;
      out_q.delete();
   endtask

   task automatic check_led();
      led_en_i = 1'b1;
      #0.5;
      checks += 2;
      assert (led_o === led_pattern(exp_mode)) else begin
         errors++;
         $display("mismatch at %0t: led_o expected %b got %b",
                  $time, led_pattern(exp_mode), led_o);
      end
      led_en_i = 1'b0;
      #0.5;
      assert (led_o === 4'b0000) else begin
         errors++;
         $display("mismatch at %0t: led_o expected 0000 got %b", $time, led_o);
      end
   endtask

   task automatic press_button(input logic nxt, input logic flp);
      @(posedge vin_clk_i);
      #0.5;
      mode_next_i = nxt;
      mode_flip_i = flp;
      @(posedge vin_clk_i);
      #0.5;
      mode_next_i = 1'b0;
      mode_flip_i = 1'b0;
      exp_mode = nxt ? step_window(exp_mode) : swap_polarity(exp_mode);
      check_led();
   endtask

   task automatic send_frame();
      for (int ln = 0; ln < FRAME_LINES; ln++) begin
         for (int c = 0; c < WA; c++) begin
            @(posedge vin_clk_i);
            #0.5;
            vin_hs_i = (c < 2);
            vin_vs_i = (ln == VP);
            vin_de_i = (ln < VP) && (c >= ML) && (c < ML + HP);
            vin_data_i = '0;
            if (vin_de_i) begin
               vin_data_i = frame_pix[ln][c - ML];
            end
         end
      end
   endtask

   task automatic check_frame();
      logic [PIX_W-1:0] exp_pix;
      logic [PIX_W-1:0] got;
      int               wait_cnt;
      int               sum;
      sum = 0;
      for (int ln = 0; ln < VP; ln++) begin
         for (int col = 0; col < HP; col++) begin
            exp_pix = frame_pix[ln][col] ^ {PIX_W{inv_expected(exp_mode, ln, col)}};
            wait_cnt = 0;
            while (out_q.size() == 0 && wait_cnt < PIX_TIMEOUT) begin
               @(negedge vin_clk_i);
               wait_cnt++;
            end
            if (out_q.size() == 0) begin
               errors++;
               $display("timeout waiting for output pixel %0d of line %0d", col, ln);
               return;
            end
            got = out_q.pop_front();
            checks++;
            assert (got === exp_pix) else begin
               errors++;
               $display("mismatch at %0t: vout_data_o expected %h got %h (line %0d pixel %0d)",
                        $time, exp_pix, got, ln, col);
            end
            sum += gray_of(frame_pix[ln][col]);
         end
      end
      prev_sum = sum;
   endtask

   task automatic run_frames(input int n);
      repeat (n) begin
         for (int y = 0; y < VP; y++) begin
            for (int x = 0; x < HP; x++) begin
               frame_pix[y][x] = PIX_W'($urandom());
            end
         end
         send_frame();
         check_frame();
      end
   endtask

   task automatic direct_path();
      checks++;
      assert (led_o === 4'b0000) else begin
         errors++;
         $display("mismatch at %0t: led_o expected 0000 got %b", $time, led_o);
      end
      repeat (3) press_button(1'b1, 1'b0);
      run_frames(2);
   endtask

   task automatic inverted_path();
      press_button(1'b0, 1'b1);
      run_frames(2);
   endtask

   task automatic block_windows();
      press_button(1'b1, 1'b0);
      press_button(1'b0, 1'b1);
      run_frames(2);
      press_button(1'b0, 1'b1);
      run_frames(2);
   endtask

   task automatic line_windows();
      press_button(1'b1, 1'b0);
      press_button(1'b0, 1'b1);
      run_frames(2);
   endtask

   // Fresh reset so the first frame sees a zero frame reference
   task automatic frame_windows();
      apply_reset();
      press_button(1'b1, 1'b0);
      press_button(1'b1, 1'b0);
      run_frames(2);
   endtask

   task automatic mode_cycling();
      repeat (4) begin
         press_button(1'b1, 1'b0);
         press_button(1'b0, 1'b1);
      end
   endtask

   initial begin
      void'($urandom(32'h2d68f199));
      vin_clk_i = 1'b0;
      errors = 0;
      checks = 0;
      since_rst = 0;
      apply_reset();
      direct_path();
      inverted_path();
      block_windows();
      line_windows();
      frame_windows();
      mode_cycling();
      checks++;
      assert (out_q.size() == 0) else begin
         errors++;
         $display("DUT produced %0d more output pixels than were sent", out_q.size());
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== binarize_top.f ====
logic/video_pkg.sv
logic/mode_pkg.sv
logic/video_if.sv
logic/rgb_to_gray.sv
logic/blk_buffer.sv
logic/lin_buffer.sv
logic/frm_buffer.sv
logic/delay_line.sv
logic/mode_ctrl.sv
logic/binarize_top.sv
testbench/tb_binarize.sv

// ==== Bender.yml ====
package:
  name: binarize

sources:
  - logic/video_pkg.sv
  - logic/mode_pkg.sv
  - logic/video_if.sv
  - logic/rgb_to_gray.sv
  - logic/blk_buffer.sv
  - logic/lin_buffer.sv
  - logic/frm_buffer.sv
  - logic/delay_line.sv
  - logic/mode_ctrl.sv
  - logic/binarize_top.sv
  - target: test
    files:
      - testbench/tb_binarize.sv
